// File: Bender.yml
# Bender manifest for the LUTRAM FIFO subsystem
package:
  name: fifo_lutram

dependencies: {}

sources:
  # Package first, every other file imports it
  - design/fifo_pkg.sv

  # RTL leaf modules, then the top level
  - design/lutram_storage.sv
  - design/fifo_ctrl.sv
  - design/fifo_out_stage.sv
  - design/fifo_lutram.sv

  # Testbench, only pulled in for simulation
  - target: any(test, simulation)
    files:
      - verification/tb_fifo_lutram.sv

// File: project.f
design/fifo_pkg.sv
design/lutram_storage.sv
design/fifo_ctrl.sv
design/fifo_out_stage.sv
design/fifo_lutram.sv
verification/tb_fifo_lutram.sv

// File: verification/tb_fifo_lutram.sv
`timescale 1ns/1ps

// Testbench for the LUTRAM FIFO subsystem.
// The stimulus drives directed and random traffic, a queue model tracks the
// words that are held, and concurrent assertions compare the DUT against it.
module tb_fifo_lutram
    import fifo_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int STEADY_CYCLES = 16;
    localparam int RANDOM_HALF  = 200;

    // Upper bound on the stimulus length
    // Each random cycle may add an idle gap of three cycles
    localparam int STIM_CYCLES = RESET_CYCLES + 20
                               + 2 * (N_ENTRIES + 7)
                               + 3 * (2 * (N_ENTRIES + 4) + STEADY_CYCLES + 6)
                               + 8 * RANDOM_HALF + N_ENTRIES + 10;

    logic       clk;
    logic       reset;
    fifo_data_t enq_data;
    logic       enq_en;
    logic       deq_en;
    logic       not_full;
    logic       almost_full;
    fifo_data_t first;
    logic       not_empty;

    // Reference model of every word held in the subsystem, RAM and register together
    fifo_data_t model_q[$];
    int         model_cnt;
    fifo_data_t model_head;

    // Consecutive clock edges without enqueue or dequeue
    int         idle_cnt;
    int         cycle_no;
    integer     seed;

    // Expected flag values for the current held word count
    logic       exp_not_empty;
    logic       exp_not_full;
    logic       exp_almost_full;

    fifo_lutram dut_i (
        .clk         (clk),
        .reset       (reset),
        .enq_data    (enq_data),
        .enq_en      (enq_en),
        .not_full    (not_full),
        .almost_full (almost_full),
        .first       (first),
        .deq_en      (deq_en),
        .not_empty   (not_empty)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // One word sits in the output register, the rest in RAM
    always_comb
    begin
        exp_not_empty   = (model_cnt > 0);
        exp_not_full    = (model_cnt == 0) || ((model_cnt - 1) != N_ENTRIES);
        exp_almost_full = ((model_cnt - 1) >= (N_ENTRIES - THRESHOLD));
    end

    // Model update on the same edge that the DUT sees the strobes
    always @(posedge clk)
    begin
        cycle_no <= cycle_no + 1;
        if (reset)
        begin
            model_q.delete();
            idle_cnt <= 0;
        end
        else
        begin
            // Pop before push so a simultaneous pair works at occupancy one
            if (deq_en)
            begin
                void'(model_q.pop_front());
            end
            if (enq_en)
            begin
                model_q.push_back(enq_data);
            end
            if (enq_en || deq_en)
            begin
                idle_cnt <= 0;
            end
            else if (idle_cnt < 15)
            begin
                idle_cnt <= idle_cnt + 1;
            end
        end
        model_cnt  <= model_q.size();
        model_head <= (model_q.size() != 0) ? model_q[0] : '0;
    end

    task automatic report_error(input string msg);
        $display("FAIL at time %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping on the first error");
    endtask

    // Reset values while reset is held, skipping the very first edge
    assert property (@(posedge clk) (reset && cycle_no > 0)
        |-> (!not_empty && almost_full && !not_full))
        else report_error("flags wrong while reset is held");

    assert property (@(posedge clk) $fell(reset) |-> (!not_empty && almost_full))
        else report_error("flags wrong on the first cycle after reset");

    assert property (@(posedge clk) $fell(reset) |=> not_full)
        else report_error("not_full not high one cycle after reset");

    // An enqueue into the fully empty subsystem shows up on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        (enq_en && model_cnt == 0) |=> (not_empty && first == $past(enq_data)))
        else report_error("bypassed word not at the output one cycle later");

    // Every dequeued word must be the oldest one in the model
    assert property (@(posedge clk) disable iff (reset)
        deq_en |-> (model_cnt > 0 && first == model_head))
        else report_error("dequeued word differs from the model head");

    // Settled flags once the subsystem has been idle for two edges
    assert property (@(posedge clk) disable iff (reset)
        (idle_cnt >= 2) |-> (not_empty == exp_not_empty))
        else report_error("not_empty does not match the held word count");

    assert property (@(posedge clk) disable iff (reset)
        (idle_cnt >= 2) |-> (not_full == exp_not_full))
        else report_error("not_full does not match the held word count");

    assert property (@(posedge clk) disable iff (reset)
        (idle_cnt >= 2) |-> (almost_full == exp_almost_full))
        else report_error("almost_full does not match the held word count");

    // One cycle of traffic
    // Requests are dropped when the flags forbid them
    task automatic step(input logic enq_req, input logic deq_req, input fifo_data_t data);
        @(posedge clk);
        #1;
        enq_en   = enq_req && not_full;
        deq_en   = deq_req && not_empty;
        enq_data = data;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step(1'b0, 1'b0, '0);
    endtask

    task automatic fill_words(input int n);
        repeat (n) step(1'b1, 1'b0, $random(seed));
    endtask

    task automatic drain_words(input int n);
        repeat (n) step(1'b0, 1'b1, '0);
    endtask

    // Fill to a level, then push and pop together so the level stays put
    task automatic steady_traffic(input int level);
        fill_words(level);
        idle_cycles(3);
        repeat (STEADY_CYCLES) step(1'b1, 1'b1, $random(seed));
        idle_cycles(3);
        drain_words(N_ENTRIES + 4);
        idle_cycles(3);
    endtask

    // Random traffic with an idle gap now and then so settled checks fire
    task automatic random_traffic(input int cycles, input bit enq_heavy);
        logic [31:0] r;
        logic        enq_req;
        logic        deq_req;
        repeat (cycles)
        begin
            r = $random(seed);
            enq_req = enq_heavy ? (r[0] | r[1]) : r[0];
            deq_req = enq_heavy ? r[2] : (r[2] | r[3]);
            step(enq_req, deq_req, $random(seed));
            if (r[7:4] == 4'h0)
            begin
                idle_cycles(3);
            end
        end
    endtask

    // Watchdog that ends the run if the stimulus overruns its bound
    initial
    begin
        #((STIM_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout: the stimulus did not finish in the expected time");
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        enq_data    = '0;
        enq_en      = 1'b0;
        deq_en      = 1'b0;
        seed        = 49;
        cycle_no    = 0;
        idle_cnt    = 0;
        model_cnt   = 0;
        model_head  = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_cycles(3);

        // Single word through the bypass path, then out again
        fill_words(1);
        idle_cycles(3);
        drain_words(1);
        idle_cycles(3);

        // Fill with no consumer until not_full drops, then drain in order
        fill_words(N_ENTRIES + 4);
        idle_cycles(3);
        drain_words(N_ENTRIES + 4);
        idle_cycles(3);

        steady_traffic(1);
        steady_traffic(4);
        steady_traffic(N_ENTRIES - 1);

        random_traffic(RANDOM_HALF, 1'b1);
        random_traffic(RANDOM_HALF, 1'b0);

        drain_words(N_ENTRIES + 4);
        idle_cycles(3);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: design/fifo_lutram.sv
`timescale 1ns/1ps

// LUTRAM FIFO with a registered output and bypass into the output register.
// Total capacity is the RAM depth plus the one word in the output register.
module fifo_lutram
    import fifo_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Producer side
    // enq_en is legal only while not_full is high
    input  fifo_data_t enq_data,
    input  logic       enq_en,
    output logic       not_full,
    output logic       almost_full,

    // Consumer side
    // first is valid whenever not_empty is high
    output fifo_data_t first,
    input  logic       deq_en,
    output logic       not_empty
);

    // Push and pop strobes for the RAM, after bypass steering
    logic        ram_enq;
    logic        ram_deq;

    // RAM pointers from the control block
    fifo_idx_t   wr_idx;
    fifo_idx_t   rd_idx;

    // Registered level flags
    fifo_flags_t flags;

    // Oldest word in the RAM
    fifo_data_t  ram_first;

    // Producer back-pressure comes straight from the RAM occupancy
    assign not_full    = flags.not_full;
    assign almost_full = flags.almost_full;

    fifo_ctrl ctrl_i (
        .clk     (clk),
        .reset   (reset),
        .ram_enq (ram_enq),
        .ram_deq (ram_deq),
        .wr_idx  (wr_idx),
        .rd_idx  (rd_idx),
        .flags   (flags)
    );

    // Writes track the full flag only, so the data path does not wait on
    // the bypass decision
    lutram_storage storage_i (
        .clk   (clk),
        .wen   (flags.not_full),
        .waddr (wr_idx),
        .wdata (enq_data),
        .raddr (rd_idx),
        .rdata (ram_first)
    );

    fifo_out_stage out_i (
        .clk           (clk),
        .reset         (reset),
        .enq_data      (enq_data),
        .enq_en        (enq_en),
        .deq_en        (deq_en),
        .first         (first),
        .not_empty     (not_empty),
        .ram_first     (ram_first),
        .ram_not_empty (flags.ram_not_empty),
        .ram_enq       (ram_enq),
        .ram_deq       (ram_deq)
    );

endmodule

// File: design/fifo_out_stage.sv
`timescale 1ns/1ps

// Output register of the LUTRAM FIFO.
// The consumer always sees a registered word. When the register is free and
// the RAM holds nothing, an incoming word goes straight into the register
// and the RAM is left untouched.
module fifo_out_stage
    import fifo_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Producer side
    input  fifo_data_t enq_data,
    input  logic       enq_en,

    // Consumer side
    input  logic       deq_en,
    output fifo_data_t first,
    output logic       not_empty,

    // Head of the RAM and its occupancy flag
    input  fifo_data_t ram_first,
    input  logic       ram_not_empty,

    // Strobes towards the control block
    output logic       ram_enq,
    output logic       ram_deq
);

    // Output register and its valid bit
    fifo_data_t first_reg;
    logic       first_valid;

    // The register can take a new word this cycle
    logic       reg_free;

    // Incoming word skips the RAM and loads the register directly
    logic       bypass;

    // Register is free if it is empty or its word leaves this cycle
    assign reg_free = deq_en || !first_valid;

    // Bypass only when nothing older waits in the RAM,
    // otherwise the new word would overtake it
    assign bypass = reg_free && !ram_not_empty;

    // A bypassed word never touches the RAM
    assign ram_enq = enq_en && !bypass;

    // Refill from the RAM whenever the register frees up and RAM has data
    assign ram_deq = reg_free && ram_not_empty;

    assign first     = first_reg;
    assign not_empty = first_valid;

    // Valid bit of the output register, seen outside as not_empty
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            first_valid <= 1'b0;
        end
        else if (bypass)
        begin
            // Stays valid only if a word actually arrived
            first_valid <= enq_en;
        end
        else if (reg_free)
        begin
            first_valid <= ram_not_empty;
        end
    end

    // Payload register, qualified by first_valid
    always_ff @(posedge clk)
    begin
        if (bypass)
        begin
            first_reg <= enq_data;
        end
        else if (reg_free)
        begin
            first_reg <= ram_first;
        end
    end

    // The consumer may only pop a word that is shown as present
    assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("fifo_out_stage: dequeue while empty");

endmodule

// File: design/fifo_ctrl.sv
`timescale 1ns/1ps

// Control block of the LUTRAM FIFO.
// Keeps the head and tail pointers into the RAM and a count of live entries.
// All flags are registered from the next-state count so that they line up
// with the pointer update they describe.
module fifo_ctrl
    import fifo_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Push and pop strobes for the RAM, from the output stage
    input  logic        ram_enq,
    input  logic        ram_deq,

    // Tail pointer, where the next entry is written
    output fifo_idx_t   wr_idx,

    // Head pointer, where the oldest entry is read
    output fifo_idx_t   rd_idx,

    // Registered level flags
    output fifo_flags_t flags
);

    // Live entries currently held in the RAM
    fifo_cnt_t cnt;

    // Count after the strobes of this cycle have been applied
    fifo_cnt_t cnt_next;

    // Step a pointer by one slot, wrapping at the last RAM slot
    // The depth need not be a power of two, so the wrap is explicit
    function automatic fifo_idx_t next_idx(input fifo_idx_t idx);
        fifo_idx_t stepped;
        if (idx == fifo_idx_t'(N_ENTRIES - 1))
        begin
            stepped = '0;
        end
        else
        begin
            stepped = idx + 1'b1;
        end
        return stepped;
    endfunction

    // Tail pointer moves on every accepted push
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_idx <= '0;
        end
        else if (ram_enq)
        begin
            wr_idx <= next_idx(wr_idx);
        end
    end

    // Head pointer moves on every pop
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_idx <= '0;
        end
        else if (ram_deq)
        begin
            rd_idx <= next_idx(rd_idx);
        end
    end

    // Next-state count
    // A push and a pop in the same cycle cancel and leave the count alone
    always_comb
    begin
        cnt_next = cnt;
        if (ram_enq && !ram_deq)
        begin
            cnt_next = cnt + 1'b1;
        end
        else if (ram_deq && !ram_enq)
        begin
            cnt_next = cnt - 1'b1;
        end
    end

    // Count and flags share one register stage
    // Flags come from cnt_next so they agree with cnt after every edge
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt   <= '0;
            flags <= FLAGS_RESET;
        end
        else
        begin
            cnt <= cnt_next;
            flags.not_full      <= (cnt_next != fifo_cnt_t'(N_ENTRIES));
            flags.almost_full   <= (cnt_next >= fifo_cnt_t'(N_ENTRIES - THRESHOLD));
            flags.ram_not_empty <= (cnt_next != '0);
        end
    end

    // The output stage only forwards enqueues the user made while not_full
    // was high, so a push into a full RAM means the producer broke the rules
    // or the bypass steering lost track of the RAM state
    assert property (@(posedge clk) disable iff (reset)
        ram_enq |-> flags.not_full)
        else $error("fifo_ctrl: enqueue into full RAM");

    // The output stage must only refill from the RAM while it holds data
    // A pop from an empty RAM would corrupt the count and the head pointer
    assert property (@(posedge clk) disable iff (reset)
        ram_deq |-> flags.ram_not_empty)
        else $error("fifo_ctrl: dequeue from empty RAM");

endmodule

// File: design/lutram_storage.sv
`timescale 1ns/1ps

// Distributed RAM array that backs the FIFO.
// Writes are registered on the clock edge, reads are purely combinational,
// which is the natural shape of a LUT-based memory.
module lutram_storage
    import fifo_pkg::*;
(
    input  logic       clk,

    // Write port
    input  logic       wen,
    input  fifo_idx_t  waddr,
    input  fifo_data_t wdata,

    // Read port
    input  fifo_idx_t  raddr,
    output fifo_data_t rdata
);

    // Storage array, one word per FIFO slot
    // Distributed RAM has no reset, so the contents start undefined
    fifo_data_t mem [N_ENTRIES];

    // The write enable only follows the full flag, not the enqueue strobe
    // Writing the slot at the tail on every non-full cycle is harmless,
    // since that slot is not live until the tail pointer moves past it
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Asynchronous read of the head entry
    // The output stage samples this on the same edge that pops the RAM
    assign rdata = mem[raddr];

endmodule

// File: design/fifo_pkg.sv
package fifo_pkg;

    // Payload width of one FIFO entry
    localparam int N_DATA_BITS = 32;

    // Number of slots in the distributed RAM
    // The output register adds one more word of total capacity
    localparam int N_ENTRIES = 8;

    // almost_full rises once this many or fewer RAM slots remain free
    localparam int THRESHOLD = 2;

    // One payload word
    typedef logic [N_DATA_BITS-1:0] fifo_data_t;

    // RAM address, used for both the head and the tail pointer
    typedef logic [$clog2(N_ENTRIES)-1:0] fifo_idx_t;

    // Live-entry count
    // One extra bit so that both 0 and N_ENTRIES can be represented
    typedef logic [$clog2(N_ENTRIES+1)-1:0] fifo_cnt_t;

    // Registered level flags produced by the control block
    typedef struct packed {
        logic not_full;
        logic almost_full;
        logic ram_not_empty;
    } fifo_flags_t;

    // Flag values held while reset is asserted
    // The FIFO looks full and empty at once, so nobody pushes or pops
    localparam fifo_flags_t FLAGS_RESET = '{
        not_full:      1'b0,
        almost_full:   1'b1,
        ram_not_empty: 1'b0
    };

endpackage
